//--- flist.f
hdl/line_pkg.sv
hdl/line_pattern.sv
hdl/line_exerciser.sv
hdl/cache_axi.sv
hdl/line_compare.sv
hdl/line_test_top.sv
test/tb_io_memory.sv
test/tb_line_test.sv

//--- hdl/cache_axi.sv
//##########################################################################
// line req/ack to io valid/ready bridge
//##########################################################################
`timescale 1ns/1ns

module cache_axi (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_cache_axi_req,
  input  line_pkg::line_req_t i_cache_axi_line_req,
  input  logic                i_axi_io_ready,
  input  line_pkg::line_t     i_axi_io_rdata,
  output logic                o_cache_axi_ack,
  output line_pkg::line_t     o_cache_axi_rdata,
  output logic                o_axi_io_valid,
  output line_pkg::io_op_e    o_axi_io_op,
  output line_pkg::addr_t     o_axi_io_addr,
  output line_pkg::line_t     o_axi_io_wdata
);
  import line_pkg::*;

  typedef enum logic [1:0] {
    B_IDLE,
    B_BUS,
    B_ACK
  } bridge_state_e;

  bridge_state_e state_q;
  io_req_t       io_q;    // request held on the bus
  line_t         rdata_q;

  assign o_axi_io_op       = io_q.op;
  assign o_axi_io_addr     = io_q.addr;
  assign o_axi_io_wdata    = io_q.wdata;
  assign o_cache_axi_rdata = rdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q         <= B_IDLE;
      o_axi_io_valid  <= 1'b0;
      o_cache_axi_ack <= 1'b0;
    end else begin
      case (state_q)
        B_IDLE: if (i_cache_axi_req) begin
          io_q.op        <= i_cache_axi_line_req.op;
          io_q.addr      <= i_cache_axi_line_req.addr;
          io_q.wdata     <= i_cache_axi_line_req.wdata;
          o_axi_io_valid <= 1'b1;
          state_q        <= B_BUS;
        end
        B_BUS: if (i_axi_io_ready) begin  // transfer completes this cycle
          o_axi_io_valid  <= 1'b0;
          if (io_q.op == OP_READ) rdata_q <= i_axi_io_rdata;
          o_cache_axi_ack <= 1'b1;
          state_q         <= B_ACK;
        end
        B_ACK: if (!i_cache_axi_req) begin
          o_cache_axi_ack <= 1'b0;
          state_q         <= B_IDLE;
        end
        default: state_q <= B_IDLE;
      endcase
    end
  end

  // back-pressure holds the whole request
  a_io_stable: assert property (@(posedge clk) disable iff (rst)
    o_axi_io_valid && !i_axi_io_ready |=>
      o_axi_io_valid && $stable(o_axi_io_op) && $stable(o_axi_io_addr)
      && $stable(o_axi_io_wdata));

  a_addr_align: assert property (@(posedge clk) disable iff (rst)
    i_cache_axi_req |-> i_cache_axi_line_req.addr[5:0] == 6'd0);

endmodule

//--- hdl/line_compare.sv
//##########################################################################
// read-back line checker
//##########################################################################
`timescale 1ns/1ns

module line_compare (
  input  logic            clk,
  input  logic            rst,
  input  logic            i_start,
  input  logic            i_valid,
  input  line_pkg::line_t i_wdata,
  input  line_pkg::line_t i_rdata,
  input  line_pkg::addr_t i_addr,
  output logic [15:0]     o_error_count,
  output line_pkg::addr_t o_first_err_addr
);

  logic seen_err_q;  // first mismatch of the run already recorded
  logic mismatch;

  assign mismatch = i_valid && (i_wdata != i_rdata);

  always_ff @(posedge clk) begin
    if (rst) begin
      o_error_count    <= '0;
      o_first_err_addr <= '0;
      seen_err_q       <= 1'b0;
    end else if (i_start) begin
      // new run
      o_error_count    <= '0;
      o_first_err_addr <= '0;
      seen_err_q       <= 1'b0;
    end else if (mismatch) begin
      if (o_error_count != 16'hffff) begin
        o_error_count <= o_error_count + 16'd1;  // saturates
      end
      if (!seen_err_q) begin
        o_first_err_addr <= i_addr;
        seen_err_q       <= 1'b1;
      end
    end
  end

endmodule

//--- hdl/line_exerciser.sv
//##########################################################################
// line write/read-back sequencer
//##########################################################################
`timescale 1ns/1ns

module line_exerciser #(
  parameter int IDLE_GAP = 16
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_start,
  input  line_pkg::addr_t     i_base_addr,
  input  logic [15:0]         i_line_count,
  input  logic                i_pat_ack,
  input  line_pkg::line_t     i_pat_line,
  input  logic                i_axi_ack,
  input  line_pkg::line_t     i_axi_rdata,
  output logic                o_busy,
  output logic                o_done,
  output logic [15:0]         o_lines_done,
  output logic                o_pat_req,
  output logic [15:0]         o_pat_index,
  output logic                o_axi_req,
  output line_pkg::line_req_t o_axi_line_req,
  output logic                o_cmp_valid,
  output line_pkg::line_t     o_cmp_wdata,
  output line_pkg::line_t     o_cmp_rdata,
  output line_pkg::addr_t     o_cmp_addr
);
  import line_pkg::*;

  localparam int GAP_W = $clog2(IDLE_GAP + 2);

  typedef enum logic [3:0] {
    S_IDLE,
    S_PAT,
    S_PAT_REL,
    S_GAP,
    S_BUS,
    S_BUS_REL,
    S_CMP,
    S_END
  } ex_state_e;

  ex_state_e        state_q;
  logic [GAP_W-1:0] gap_q;
  io_op_e           op_q;
  addr_t            addr_q;
  logic [15:0]      index_q;
  logic [15:0]      count_q;
  logic [15:0]      lines_q;
  line_t            wdata_q;
  line_t            rdata_q;

  assign o_busy       = (state_q != S_IDLE);
  assign o_done       = (state_q == S_END);
  assign o_cmp_valid  = (state_q == S_CMP);  // single cycle, addr_q not yet stepped
  assign o_lines_done = lines_q;
  assign o_pat_index  = index_q;
  assign o_cmp_wdata  = wdata_q;
  assign o_cmp_rdata  = rdata_q;
  assign o_cmp_addr   = addr_q;

  assign o_axi_line_req = '{op: op_q, addr: addr_q, wdata: wdata_q};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= S_IDLE;
      gap_q     <= '0;
      op_q      <= OP_WRITE;
      addr_q    <= '0;
      index_q   <= '0;
      count_q   <= '0;
      lines_q   <= '0;
      o_pat_req <= 1'b0;
      o_axi_req <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: if (i_start) begin
          addr_q  <= i_base_addr;
          index_q <= '0;
          count_q <= i_line_count;
          lines_q <= '0;
          state_q <= (i_line_count == 16'd0) ? S_END : S_PAT;
        end
        S_PAT: begin
          if (o_pat_req && i_pat_ack) begin
            o_pat_req <= 1'b0;
            wdata_q   <= i_pat_line;
            state_q   <= S_PAT_REL;
          end else if (!i_pat_ack) begin
            o_pat_req <= 1'b1;
          end
        end
        S_PAT_REL: if (!i_pat_ack) begin
          op_q    <= OP_WRITE;
          gap_q   <= GAP_W'(IDLE_GAP);
          state_q <= S_GAP;
        end
        S_GAP: begin
          // wait out the gap, then raise the bus request
          if (gap_q == '0) begin
            o_axi_req <= 1'b1;
            state_q   <= S_BUS;
          end else begin
            gap_q <= gap_q - 1'b1;
          end
        end
        S_BUS: if (i_axi_ack) begin
          o_axi_req <= 1'b0;
          if (op_q == OP_READ) rdata_q <= i_axi_rdata;
          state_q <= S_BUS_REL;
        end
        S_BUS_REL: if (!i_axi_ack) begin
          if (op_q == OP_WRITE) begin  // now read the same line back
            op_q    <= OP_READ;
            gap_q   <= GAP_W'(IDLE_GAP);
            state_q <= S_GAP;
          end else begin
            state_q <= S_CMP;
          end
        end
        S_CMP: begin
          lines_q <= lines_q + 16'd1;
          index_q <= index_q + 16'd1;
          addr_q  <= addr_q + addr_t'(LINE_BYTES);
          op_q    <= OP_WRITE;
          state_q <= (lines_q + 16'd1 == count_q) ? S_END : S_PAT;
        end
        S_END:   state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // four-phase rule toward the bridge
  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    $fell(o_axi_req) |-> $past(i_axi_ack));

endmodule

//--- hdl/line_pattern.sv
//##########################################################################
// lfsr line pattern generator
//##########################################################################
`timescale 1ns/1ns

module line_pattern #(
  parameter logic [31:0] PATTERN_SEED = 32'h1357_9bdf
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            i_req,
  input  logic [15:0]     i_index,
  output logic            o_ack,
  output line_pkg::line_t o_line
);
  import line_pkg::*;

  typedef enum logic [1:0] {
    P_IDLE,
    P_RUN,
    P_ACK
  } pat_state_e;

  pat_state_e  state_q;
  logic [3:0]  word_q;
  logic [31:0] lfsr_q;
  logic [31:0] lfsr_next;

  // one galois step, shift right and fold the taps on a carry out
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ LFSR_TAPS;
    return n;
  endfunction

  assign lfsr_next = lfsr_step(lfsr_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= P_IDLE;
      word_q  <= '0;
      o_ack   <= 1'b0;
    end else begin
      case (state_q)
        P_IDLE: if (i_req) begin
          lfsr_q  <= PATTERN_SEED ^ {16'h0000, i_index};  // seed per line
          word_q  <= '0;
          state_q <= P_RUN;
        end
        P_RUN: begin
          o_line[word_q] <= lfsr_next;
          lfsr_q         <= lfsr_next;
          word_q         <= word_q + 4'd1;
          if (word_q == 4'd15) begin  // last word lands now
            o_ack   <= 1'b1;
            state_q <= P_ACK;
          end
        end
        P_ACK: if (!i_req) begin
          o_ack   <= 1'b0;
          state_q <= P_IDLE;
        end
        default: state_q <= P_IDLE;
      endcase
    end
  end

endmodule

//--- hdl/line_pkg.sv
//##########################################################################
// cache line exerciser shared types
//##########################################################################

package line_pkg;

  localparam int LINE_BITS  = 512;
  localparam int ADDR_BITS  = 64;
  localparam int WORD_BITS  = 32;
  localparam int LINE_WORDS = LINE_BITS / WORD_BITS;
  localparam int LINE_BYTES = LINE_BITS / 8;  // address step per line

  // galois tap mask, shared with the testbench model
  localparam logic [31:0] LFSR_TAPS = 32'h8000_0057;

  typedef logic [LINE_WORDS-1:0][WORD_BITS-1:0] line_t;  // word 0 in the low bits
  typedef logic [ADDR_BITS-1:0]                 addr_t;  // byte address, low 6 bits zero

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } io_op_e;

  // exerciser to bridge, held while req is high
  typedef struct packed {
    io_op_e op;
    addr_t  addr;
    line_t  wdata;
  } line_req_t;

  // request as held on the io bus
  typedef struct packed {
    io_op_e op;
    addr_t  addr;
    line_t  wdata;
  } io_req_t;

endpackage

//--- hdl/line_test_top.sv
//##########################################################################
// cache line bus exerciser top
//##########################################################################
`timescale 1ns/1ns

module line_test_top #(
  parameter int          IDLE_GAP     = 16,
  parameter logic [31:0] PATTERN_SEED = 32'h1357_9bdf
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_start,
  input  line_pkg::addr_t  i_base_addr,
  input  logic [15:0]      i_line_count,
  input  logic             i_axi_io_ready,
  input  line_pkg::line_t  i_axi_io_rdata,
  output logic             o_busy,
  output logic             o_done,
  output logic [15:0]      o_lines_done,
  output logic [15:0]      o_error_count,
  output line_pkg::addr_t  o_first_err_addr,
  output logic             o_axi_io_valid,
  output line_pkg::io_op_e o_axi_io_op,
  output line_pkg::addr_t  o_axi_io_addr,
  output line_pkg::line_t  o_axi_io_wdata
);
  import line_pkg::*;

  logic        pat_req;
  logic        pat_ack;
  logic [15:0] pat_index;
  line_t       pat_line;
  logic        axi_req;
  logic        axi_ack;
  line_req_t   axi_line_req;
  line_t       axi_rdata;
  logic        cmp_valid;
  line_t       cmp_wdata;
  line_t       cmp_rdata;
  addr_t       cmp_addr;

  line_exerciser #(
    .IDLE_GAP (IDLE_GAP)
  ) u_exerciser (
    .clk            (clk),
    .rst            (rst),
    .i_start        (i_start),
    .i_base_addr    (i_base_addr),
    .i_line_count   (i_line_count),
    .i_pat_ack      (pat_ack),
    .i_pat_line     (pat_line),
    .i_axi_ack      (axi_ack),
    .i_axi_rdata    (axi_rdata),
    .o_busy         (o_busy),
    .o_done         (o_done),
    .o_lines_done   (o_lines_done),
    .o_pat_req      (pat_req),
    .o_pat_index    (pat_index),
    .o_axi_req      (axi_req),
    .o_axi_line_req (axi_line_req),
    .o_cmp_valid    (cmp_valid),
    .o_cmp_wdata    (cmp_wdata),
    .o_cmp_rdata    (cmp_rdata),
    .o_cmp_addr     (cmp_addr)
  );

  line_pattern #(
    .PATTERN_SEED (PATTERN_SEED)
  ) u_pattern (
    .clk     (clk),
    .rst     (rst),
    .i_req   (pat_req),
    .i_index (pat_index),
    .o_ack   (pat_ack),
    .o_line  (pat_line)
  );

  cache_axi u_cache_axi (
    .clk                  (clk),
    .rst                  (rst),
    .i_cache_axi_req      (axi_req),
    .i_cache_axi_line_req (axi_line_req),
    .i_axi_io_ready       (i_axi_io_ready),
    .i_axi_io_rdata       (i_axi_io_rdata),
    .o_cache_axi_ack      (axi_ack),
    .o_cache_axi_rdata    (axi_rdata),
    .o_axi_io_valid       (o_axi_io_valid),
    .o_axi_io_op          (o_axi_io_op),
    .o_axi_io_addr        (o_axi_io_addr),
    .o_axi_io_wdata       (o_axi_io_wdata)
  );

  line_compare u_compare (
    .clk              (clk),
    .rst              (rst),
    .i_start          (i_start && !o_busy),  // only a start the exerciser accepts
    .i_valid          (cmp_valid),
    .i_wdata          (cmp_wdata),
    .i_rdata          (cmp_rdata),
    .i_addr           (cmp_addr),
    .o_error_count    (o_error_count),
    .o_first_err_addr (o_first_err_addr)
  );

endmodule

//--- run.sh
#!/bin/sh
# build and run the line exerciser testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f flist.f \
  --top-module tb_line_test -o sim_line_test
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_line_test)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
  exit 0
fi
exit 1

//--- test/tb_io_memory.sv
//##########################################################################
// io bus memory model
//##########################################################################
`timescale 1ns/1ns

module tb_io_memory (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_valid,
  input  line_pkg::io_op_e i_op,
  input  line_pkg::addr_t  i_addr,
  input  line_pkg::line_t  i_wdata,
  input  logic             i_force_delay,  // use i_delay instead of a random one
  input  logic [2:0]       i_delay,
  input  logic             i_corrupt_en,
  input  line_pkg::addr_t  i_corrupt_addr,
  output logic             o_ready,
  output line_pkg::line_t  o_rdata
);
  import line_pkg::*;

  line_t      mem [addr_t];  // sparse, keyed by line address
  addr_t      wr_log [$];    // write addresses in bus order
  logic       active_q;
  logic [2:0] wait_q;

  // unwritten lines read back a fill made from the whole address
  function automatic line_t read_line(input addr_t a);
    line_t d;
    if (mem.exists(a)) d = mem[a];
    else d = {LINE_WORDS{a[63:32] ^ a[31:0] ^ 32'ha5a5_0f0f}};
    if (i_corrupt_en && a == i_corrupt_addr) begin
      d[0][0] = ~d[0][0];  // single bit flip
    end
    return d;
  endfunction

  initial begin
    o_ready = 1'b0;
    o_rdata = '0;
  end

  always @(posedge clk) begin
    if (rst) begin
      o_ready  <= 1'b0;
      active_q <= 1'b0;
      wait_q   <= '0;
    end else if (o_ready) begin
      // valid and ready both high, transfer done
      o_ready  <= 1'b0;
      active_q <= 1'b0;
      if (i_op == OP_WRITE) begin
        mem[i_addr] = i_wdata;
        wr_log.push_back(i_addr);
      end
    end else if (i_valid) begin
      if (!active_q) begin
        active_q <= 1'b1;
        wait_q   <= i_force_delay ? i_delay : 3'($urandom % 8);
      end else if (wait_q == 3'd0) begin
        o_ready <= 1'b1;
        o_rdata <= read_line(i_addr);  // data rides with ready
      end else begin
        wait_q <= wait_q - 3'd1;
      end
    end
  end

endmodule

//--- test/tb_line_test.sv
//##########################################################################
// line exerciser testbench
//##########################################################################
`timescale 1ns/1ns

module tb_line_test;
  import line_pkg::*;

  localparam int          IDLE_GAP     = 16;
  localparam logic [31:0] PATTERN_SEED = 32'h1357_9bdf;
  localparam int          LINE_CYCLES  = 2 * IDLE_GAP + 60;  // worst case per line
  localparam int          TOTAL_LINES  = 8 + 6 + 4 + 4 + 4;
  localparam longint      WATCHDOG_NS  = longint'(TOTAL_LINES * LINE_CYCLES * 4) + 2000;

  localparam addr_t BASE_A = 64'h0000_0000_8000_0000;
  localparam addr_t BASE_B = 64'h0000_0000_4000_0000;
  localparam addr_t BASE_C = 64'h0000_0000_1000_0000;
  localparam addr_t BASE_D = 64'h0000_0000_2000_0000;
  localparam addr_t BASE_E = 64'h0000_0001_0000_0000;

  typedef logic [LINE_BITS-1:0] wide_t;

  logic        clk;
  logic        rst;
  logic        start;
  addr_t       base_addr;
  logic [15:0] line_count;
  logic        force_delay;
  logic [2:0]  delay_val;
  logic        corrupt_en;
  addr_t       corrupt_addr;
  logic        io_ready;
  line_t       io_rdata;
  logic        busy;
  logic        done;
  logic [15:0] lines_done;
  logic [15:0] error_count;
  addr_t       first_err_addr;
  logic        io_valid;
  io_op_e      io_op;
  addr_t       io_addr;
  line_t       io_wdata;

  string cur_test;
  int    test_errs;
  int    tests_passed;
  int    tests_failed;

  line_test_top #(
    .IDLE_GAP     (IDLE_GAP),
    .PATTERN_SEED (PATTERN_SEED)
  ) i_line_test_top (
    .clk              (clk),
    .rst              (rst),
    .i_start          (start),
    .i_base_addr      (base_addr),
    .i_line_count     (line_count),
    .i_axi_io_ready   (io_ready),
    .i_axi_io_rdata   (io_rdata),
    .o_busy           (busy),
    .o_done           (done),
    .o_lines_done     (lines_done),
    .o_error_count    (error_count),
    .o_first_err_addr (first_err_addr),
    .o_axi_io_valid   (io_valid),
    .o_axi_io_op      (io_op),
    .o_axi_io_addr    (io_addr),
    .o_axi_io_wdata   (io_wdata)
  );

  tb_io_memory u_io_memory (
    .clk            (clk),
    .rst            (rst),
    .i_valid        (io_valid),
    .i_op           (io_op),
    .i_addr         (io_addr),
    .i_wdata        (io_wdata),
    .i_force_delay  (force_delay),
    .i_delay        (delay_val),
    .i_corrupt_en   (corrupt_en),
    .i_corrupt_addr (corrupt_addr),
    .o_ready        (io_ready),
    .o_rdata        (io_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reference pattern, galois steps from seed xor index
  function automatic line_t expected_line(input logic [15:0] idx);
    logic [31:0] s;
    logic        out_bit;
    line_t       l;
    s = PATTERN_SEED ^ {16'h0000, idx};
    for (int j = 0; j < LINE_WORDS; j++) begin
      out_bit = s[0];
      s = s >> 1;
      if (out_bit) s = s ^ LFSR_TAPS;
      l[j] = s;
    end
    return l;
  endfunction

  task automatic check_eq(input string what, input wide_t exp, input wide_t act);
    assert (act === exp) else begin
      $display("Mismatch %s %s: expected %0h actual %0h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic report_test();
    if (test_errs == 0) begin
      tests_passed++;
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", cur_test, test_errs);
    end
  endtask

  task automatic start_run(input addr_t base, input logic [15:0] count);
    @(posedge clk);
    check_eq("busy before start", wide_t'(1'b0), wide_t'(busy));
    start      <= 1'b1;
    base_addr  <= base;
    line_count <= count;
    u_io_memory.wr_log.delete();
    u_io_memory.mem.delete();
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_done(input int lines);
    int limit;
    bit seen;
    bit dropped;
    limit   = (lines + 1) * LINE_CYCLES;
    seen    = 1'b0;
    dropped = 1'b0;
    for (int i = 0; i < limit && !seen; i++) begin
      @(posedge clk);
      seen = done;
      if (!busy) dropped = 1'b1;
    end
    assert (seen) else begin
      $display("%s: DUT gave no done pulse within %0d cycles", cur_test, limit);
      test_errs++;
    end
    assert (!dropped) else begin
      $display("%s: busy went low before the done pulse", cur_test);
      test_errs++;
    end
    if (seen) begin
      @(posedge clk);  // done is a single-cycle pulse
      check_eq("done after pulse", wide_t'(1'b0), wide_t'(done));
      check_eq("busy after done", wide_t'(1'b0), wide_t'(busy));
    end
  endtask

  // bus write order and stored data against the reference pattern
  task automatic check_memory(input addr_t base, input int n);
    addr_t a;
    check_eq("write count", wide_t'(n), wide_t'(u_io_memory.wr_log.size()));
    for (int k = 0; k < n; k++) begin
      a = base + addr_t'(k) * addr_t'(LINE_BYTES);
      if (k < u_io_memory.wr_log.size()) begin
        check_eq("write addr", wide_t'(a), wide_t'(u_io_memory.wr_log[k]));
      end
      check_eq("line data", wide_t'(expected_line(16'(k))), wide_t'(u_io_memory.mem[a]));
    end
  endtask

  task automatic clean_run();
    begin_test("clean_run");
    start_run(BASE_A, 16'd8);
    wait_done(8);
    check_eq("lines_done", wide_t'(16'd8), wide_t'(lines_done));
    check_eq("error_count", wide_t'(16'd0), wide_t'(error_count));
    report_test();
  endtask

  task automatic memory_contents();
    begin_test("memory_contents");
    check_memory(BASE_A, 8);  // left over from clean_run
    report_test();
  endtask

  task automatic corrupted_read();
    begin_test("corrupted_read");
    corrupt_en   <= 1'b1;
    corrupt_addr <= BASE_B + addr_t'(192);  // line 3
    start_run(BASE_B, 16'd6);
    wait_done(6);
    check_eq("lines_done", wide_t'(16'd6), wide_t'(lines_done));
    check_eq("error_count", wide_t'(16'd1), wide_t'(error_count));
    check_eq("first_err_addr", wide_t'(BASE_B + addr_t'(192)), wide_t'(first_err_addr));
    corrupt_en <= 1'b0;
    report_test();
  endtask

  task automatic zero_then_restart();
    begin_test("zero_then_restart");
    start_run(BASE_C, 16'd0);
    wait_done(0);
    check_eq("empty lines_done", wide_t'(16'd0), wide_t'(lines_done));
    start_run(BASE_D, 16'd4);  // counts from corrupted_read must be gone
    wait_done(4);
    check_eq("lines_done", wide_t'(16'd4), wide_t'(lines_done));
    check_eq("error_count", wide_t'(16'd0), wide_t'(error_count));
    check_eq("first_err_addr", wide_t'(addr_t'(0)), wide_t'(first_err_addr));
    check_memory(BASE_D, 4);
    report_test();
  endtask

  task automatic latency_independence();
    begin_test("latency_independence");
    force_delay <= 1'b1;
    delay_val   <= 3'd0;
    start_run(BASE_E, 16'd4);
    wait_done(4);
    check_eq("fast lines_done", wide_t'(16'd4), wide_t'(lines_done));
    check_eq("fast error_count", wide_t'(16'd0), wide_t'(error_count));
    check_memory(BASE_E, 4);
    delay_val <= 3'd7;
    start_run(BASE_E, 16'd4);  // same lines, slowest memory
    wait_done(4);
    check_eq("slow lines_done", wide_t'(16'd4), wide_t'(lines_done));
    check_eq("slow error_count", wide_t'(16'd0), wide_t'(error_count));
    check_memory(BASE_E, 4);
    force_delay <= 1'b0;
    report_test();
  endtask

  initial begin
    void'($urandom(32'h6dc0_642d));
    rst          = 1'b1;
    start        = 1'b0;
    base_addr    = '0;
    line_count   = '0;
    force_delay  = 1'b0;
    delay_val    = '0;
    corrupt_en   = 1'b0;
    corrupt_addr = '0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    clean_run();
    memory_contents();
    corrupted_read();
    zero_then_restart();
    latency_independence();

    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // hard stop if a run never completes
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
    $display("=== FAIL ===");
    $finish;
  end

endmodule
